// ==== wdata_bus_pkg.sv ====
package wdata_bus_pkg;
  // Narrow beat fields on the upstream side.
  localparam int NARROW_DATA_W = 16;
  localparam int NARROW_STRB_W = 2;

  // Wide beat fields on the downstream side.
  localparam int WIDE_DATA_W = 32;
  localparam int WIDE_STRB_W = 4;

  // Narrow lanes packed into one wide beat.
  localparam int LANE_COUNT = WIDE_DATA_W / NARROW_DATA_W;

  // Stored narrow beat is {data, strobe, last}, data at the top.
  localparam int NARROW_BEAT_W = NARROW_DATA_W + NARROW_STRB_W + 1;

  // Wide data seen either as one word or as lanes, lane 0 in the low half.
  typedef union packed {
    logic [WIDE_DATA_W-1:0]                word;
    logic [LANE_COUNT-1:0][NARROW_DATA_W-1:0] lane;
  } wide_data_u;
endpackage

// ==== wdata_buf_pkg.sv ====
package wdata_buf_pkg;
  // RAM sizing.
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = 3;
  localparam int FIFO_CNT_W = 4;

  // Slicer sizing.
  // Threshold leaves one free slot for the read already in flight.
  localparam int SLICER_DEPTH     = 3;
  localparam int SLICER_THRESHOLD = 2;
  localparam int SLICER_PTR_W     = 2;
  localparam int SLICER_CNT_W     = 2;
endpackage

// ==== wdata_ram.sv ====
module wdata_ram (
  input  var logic                                i_clk,
  input  var logic                                i_write_valid,
  input  var logic [wdata_buf_pkg::FIFO_PTR_W-1:0]    i_write_address,
  input  var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] i_write_data,
  input  var logic                                i_read_valid,
  input  var logic [wdata_buf_pkg::FIFO_PTR_W-1:0]    i_read_address,
  output var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] o_read_data
);
  import wdata_bus_pkg::*;
  import wdata_buf_pkg::*;

  logic [NARROW_BEAT_W-1:0] mem [FIFO_DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_write_valid) begin
      mem[i_write_address] <= i_write_data;
    end
  end

  // Read word is registered, one cycle of latency.
  always_ff @(posedge i_clk) begin
    if (i_read_valid) begin
      o_read_data <= mem[i_read_address];
    end
  end
endmodule

// ==== wdata_slicer.sv ====
module wdata_slicer (
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_clear,
  input  var logic                                i_push,
  input  var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] i_data,
  input  var logic                                i_pop,
  output var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] o_data,
  output var logic                                o_empty,
  output var logic                                o_almost_full,
  output var logic                                o_full
);
  import wdata_bus_pkg::*;
  import wdata_buf_pkg::*;

  logic [NARROW_BEAT_W-1:0] entries [SLICER_DEPTH];
  logic [SLICER_PTR_W-1:0]  write_ptr;
  logic [SLICER_PTR_W-1:0]  read_ptr;
  logic [SLICER_CNT_W-1:0]  count;
  logic [SLICER_CNT_W-1:0]  count_next;

  // Wraps at the last entry, depth is not a power of two.
  function automatic logic [SLICER_PTR_W-1:0] next_ptr(logic [SLICER_PTR_W-1:0] ptr);
    if (ptr == SLICER_PTR_W'(SLICER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_comb begin
    count_next = count;
    if (i_clear) begin
      count_next = '0;
    end else begin
      case ({i_push, i_pop})
        2'b10:   count_next = count + 1'b1;
        2'b01:   count_next = count - 1'b1;
        default: count_next = count;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      write_ptr     <= '0;
      read_ptr      <= '0;
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= 1'b0;
      o_full        <= 1'b0;
    end else begin
      if (i_clear) begin
        write_ptr <= '0;
        read_ptr  <= '0;
      end else begin
        if (i_push) begin
          write_ptr <= next_ptr(write_ptr);
        end
        if (i_pop) begin
          read_ptr <= next_ptr(read_ptr);
        end
      end
      count <= count_next;
      // Flags come from the next count so they are ready at the edge.
      o_empty       <= (count_next == '0);
      o_almost_full <= (count_next >= SLICER_CNT_W'(SLICER_THRESHOLD));
      o_full        <= (count_next == SLICER_CNT_W'(SLICER_DEPTH));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      entries[write_ptr] <= i_data;
    end
  end

  always_comb begin
    o_data = entries[read_ptr];
  end
endmodule

// ==== wdata_fifo.sv ====
module wdata_fifo (
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_clear,
  input  var logic                                i_in_valid,
  output var logic                                o_in_accept,
  input  var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] i_in_beat,
  output var logic                                o_out_valid,
  input  var logic                                i_out_accept,
  output var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] o_out_beat,
  output var logic                                o_fifo_empty,
  output var logic                                o_fifo_full
);
  import wdata_bus_pkg::*;
  import wdata_buf_pkg::*;

  logic [FIFO_PTR_W-1:0]    write_ptr;
  logic [FIFO_PTR_W-1:0]    read_ptr;
  logic [FIFO_CNT_W-1:0]    ram_count;
  logic [FIFO_CNT_W-1:0]    ram_count_next;
  logic                     ram_empty;
  logic                     ram_full;
  logic                     ram_push;
  logic                     ram_pop;
  logic [NARROW_BEAT_W-1:0] ram_read_data;
  logic                     slicer_push;
  logic                     slicer_pop;
  logic                     slicer_empty;
  logic                     slicer_almost_full;
  logic                     slicer_full;

  // A beat between RAM and slicer still counts as stored.
  always_comb begin
    o_fifo_empty = ram_empty && slicer_empty && !slicer_push;
    o_fifo_full  = ram_full && slicer_full;
  end

  always_comb begin
    o_in_accept = !ram_full;
    ram_push    = i_in_valid && !ram_full;
    // Read only when the slicer can take the word one cycle later.
    ram_pop     = !ram_empty && !slicer_almost_full;
  end

  always_comb begin
    ram_count_next = ram_count;
    if (i_clear) begin
      ram_count_next = '0;
    end else begin
      case ({ram_push, ram_pop})
        2'b10:   ram_count_next = ram_count + 1'b1;
        2'b01:   ram_count_next = ram_count - 1'b1;
        default: ram_count_next = ram_count;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      write_ptr   <= '0;
      read_ptr    <= '0;
      ram_count   <= '0;
      ram_empty   <= 1'b1;
      ram_full    <= 1'b0;
      slicer_push <= 1'b0;
    end else begin
      if (i_clear) begin
        write_ptr <= '0;
        read_ptr  <= '0;
      end else begin
        write_ptr <= write_ptr + FIFO_PTR_W'(ram_push);
        read_ptr  <= read_ptr + FIFO_PTR_W'(ram_pop);
      end
      ram_count <= ram_count_next;
      ram_empty <= (ram_count_next == '0);
      ram_full  <= (ram_count_next == FIFO_CNT_W'(FIFO_DEPTH));
      // A read issued during clear must not land in the slicer.
      slicer_push <= ram_pop && !i_clear;
    end
  end

  wdata_ram u_ram (
    .i_clk           (i_clk),
    .i_write_valid   (ram_push),
    .i_write_address (write_ptr),
    .i_write_data    (i_in_beat),
    .i_read_valid    (ram_pop),
    .i_read_address  (read_ptr),
    .o_read_data     (ram_read_data)
  );

  always_comb begin
    o_out_valid = !slicer_empty;
    slicer_pop  = o_out_valid && i_out_accept;
  end

  wdata_slicer u_slicer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_clear       (i_clear),
    .i_push        (slicer_push),
    .i_data        (ram_read_data),
    .i_pop         (slicer_pop),
    .o_data        (o_out_beat),
    .o_empty       (slicer_empty),
    .o_almost_full (slicer_almost_full),
    .o_full        (slicer_full)
  );
endmodule

// ==== wdata_req_ack_rx.sv ====
module wdata_req_ack_rx (
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_req,
  output var logic                                o_ack,
  input  var logic [wdata_bus_pkg::NARROW_DATA_W-1:0] i_data,
  input  var logic [wdata_bus_pkg::NARROW_STRB_W-1:0] i_strb,
  input  var logic                                i_last,
  output var logic                                o_valid,
  input  var logic                                i_accept,
  output var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] o_beat
);
  import wdata_bus_pkg::*;

  // Out of reset a request must be seen low before the first capture.
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ACKED,
    PH_WAIT_REQ_LOW
  } phase_e;

  phase_e                   phase;
  logic                     hold_valid;
  logic [NARROW_BEAT_W-1:0] hold_beat;
  logic                     capture;

  // Back-pressure stalls here, no capture while the holding register is full.
  always_comb begin
    capture = (phase == PH_IDLE) && i_req && !hold_valid;
    o_ack   = (phase == PH_ACKED);
    o_valid = hold_valid;
    o_beat  = hold_beat;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase      <= PH_WAIT_REQ_LOW;
      hold_valid <= 1'b0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (capture) begin
            phase <= PH_ACKED;
          end
        end
        PH_ACKED: begin
          if (!i_req) begin
            phase <= PH_IDLE;
          end
        end
        default: begin
          if (!i_req) begin
            phase <= PH_IDLE;
          end
        end
      endcase
      if (capture) begin
        hold_valid <= 1'b1;
      end else if (i_accept) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (capture) begin
      hold_beat <= {i_data, i_strb, i_last};
    end
  end
endmodule

// ==== wdata_lane_packer.sv ====
module wdata_lane_packer (
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_valid,
  output var logic                                o_accept,
  input  var logic [wdata_bus_pkg::NARROW_BEAT_W-1:0] i_beat,
  output var logic                                o_valid,
  input  var logic                                i_ready,
  output var wdata_bus_pkg::wide_data_u            o_data,
  output var logic [wdata_bus_pkg::WIDE_STRB_W-1:0]   o_strb
);
  import wdata_bus_pkg::*;

  localparam int LANE_IDX_W = $clog2(LANE_COUNT);

  logic [LANE_IDX_W-1:0]    lane_idx;
  logic [NARROW_DATA_W-1:0] beat_data;
  logic [NARROW_STRB_W-1:0] beat_strb;
  logic                     beat_last;
  logic                     pop;
  logic                     close_beat;

  always_comb begin
    beat_data = i_beat[NARROW_BEAT_W-1 -: NARROW_DATA_W];
    beat_strb = i_beat[1 +: NARROW_STRB_W];
    beat_last = i_beat[0];
  end

  // Stalled while a finished wide beat waits for the downstream.
  always_comb begin
    o_accept   = !o_valid || i_ready;
    pop        = i_valid && o_accept;
    close_beat = (lane_idx == LANE_IDX_W'(LANE_COUNT - 1)) || beat_last;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      lane_idx <= '0;
      o_valid  <= 1'b0;
    end else if (pop) begin
      lane_idx <= close_beat ? '0 : lane_idx + 1'b1;
      o_valid  <= close_beat;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Lane 0 clears the upper strobes, so last on lane 0 leaves them at zero.
  always_ff @(posedge i_clk) begin
    if (pop) begin
      o_data.lane[lane_idx] <= beat_data;
      if (lane_idx == '0) begin
        o_strb <= WIDE_STRB_W'(beat_strb);
      end else begin
        o_strb[lane_idx*NARROW_STRB_W +: NARROW_STRB_W] <= beat_strb;
      end
    end
  end
endmodule

// ==== wdata_packer_top.sv ====
module wdata_packer_top (
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_clear,
  input  var logic                                i_req,
  output var logic                                o_ack,
  input  var logic [wdata_bus_pkg::NARROW_DATA_W-1:0] i_data,
  input  var logic [wdata_bus_pkg::NARROW_STRB_W-1:0] i_strb,
  input  var logic                                i_last,
  output var logic                                o_valid,
  input  var logic                                i_ready,
  output var logic [wdata_bus_pkg::WIDE_DATA_W-1:0]   o_data,
  output var logic [wdata_bus_pkg::WIDE_STRB_W-1:0]   o_strb,
  output var logic                                o_fifo_empty,
  output var logic                                o_fifo_full
);
  import wdata_bus_pkg::*;

  logic                     in_valid;
  logic                     in_accept;
  logic [NARROW_BEAT_W-1:0] in_beat;
  logic                     out_valid;
  logic                     out_accept;
  logic [NARROW_BEAT_W-1:0] out_beat;
  wide_data_u               wide_data;

  wdata_req_ack_rx u_rx (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_req    (i_req),
    .o_ack    (o_ack),
    .i_data   (i_data),
    .i_strb   (i_strb),
    .i_last   (i_last),
    .o_valid  (in_valid),
    .i_accept (in_accept),
    .o_beat   (in_beat)
  );

  wdata_fifo u_fifo (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (i_clear),
    .i_in_valid   (in_valid),
    .o_in_accept  (in_accept),
    .i_in_beat    (in_beat),
    .o_out_valid  (out_valid),
    .i_out_accept (out_accept),
    .o_out_beat   (out_beat),
    .o_fifo_empty (o_fifo_empty),
    .o_fifo_full  (o_fifo_full)
  );

  wdata_lane_packer u_packer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (out_valid),
    .o_accept (out_accept),
    .i_beat   (out_beat),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_data   (wide_data),
    .o_strb   (o_strb)
  );

  // Downstream sees the assembled lanes as one word.
  assign o_data = wide_data.word;
endmodule

// ==== tb_wdata_packer.sv ====
module tb_wdata_packer;
  localparam int NUM_ROWS     = 8;
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;
  localparam int ACK_LIMIT    = 20;
  localparam int EXP_SLOTS    = 128;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_clear;
  logic        i_req;
  logic        o_ack;
  logic [15:0] i_data;
  logic [1:0]  i_strb;
  logic        i_last;
  logic        o_valid;
  logic        i_ready = 1'b0;
  logic [31:0] o_data;
  logic [3:0]  o_strb;
  logic        o_fifo_empty;
  logic        o_fifo_full;

  // Test table, one row per test.
  string       test_name  [NUM_ROWS];
  int          test_beats [NUM_ROWS];
  int          test_burst [NUM_ROWS];
  logic [15:0] test_first [NUM_ROWS];
  int          test_ready [NUM_ROWS];
  bit          test_clear [NUM_ROWS];

  // Expected wide beats, written by the test and consumed by the monitor.
  logic [31:0] exp_data [EXP_SLOTS];
  logic [3:0]  exp_strb [EXP_SLOTS];
  logic [31:0] exp_mask [EXP_SLOTS];
  int          exp_wr = 0;
  int          exp_rd = 0;

  string       cur_name = "reset";
  int          test_errors = 0;
  int          monitor_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          full_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          ready_mode = READY_HIGH;
  int          mode_now = READY_HIGH;
  int          pulse_req = 0;
  int          pulse_done = 0;
  bit          pulse_now = 1'b0;
  int unsigned lcg_state = 36;

  wdata_packer_top UUT (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (i_clear),
    .i_req        (i_req),
    .o_ack        (o_ack),
    .i_data       (i_data),
    .i_strb       (i_strb),
    .i_last       (i_last),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_data       (o_data),
    .o_strb       (o_strb),
    .o_fifo_empty (o_fifo_empty),
    .o_fifo_full  (o_fifo_full)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] beat_data(input int row, input int idx);
    return test_first[row] + 16'(idx * 'h0111);
  endfunction

  function automatic logic [1:0] beat_strb(input int idx);
    return 2'((idx % 3) + 1);
  endfunction

  function automatic logic beat_last(input int row, input int idx);
    return ((idx + 1) % test_burst[row] == 0) || (idx == test_beats[row] - 1);
  endfunction

  task automatic set_row(input int idx, input string name, input int beats, input int burst,
                         input logic [15:0] first, input int ready, input bit clear);
    test_name[idx]  = name;
    test_beats[idx] = beats;
    test_burst[idx] = burst;
    test_first[idx] = first;
    test_ready[idx] = ready;
    test_clear[idx] = clear;
  endtask

  task automatic load_table();
    set_row(0, "even_burst",  8,  8,  16'h1000, READY_HIGH,   1'b0);
    set_row(1, "odd_burst",   7,  7,  16'h2000, READY_HIGH,   1'b0);
    set_row(2, "random_a",    9,  3,  16'h3000, READY_RANDOM, 1'b0);
    set_row(3, "random_b",    12, 4,  16'h4000, READY_RANDOM, 1'b0);
    set_row(4, "random_c",    11, 5,  16'h5000, READY_RANDOM, 1'b0);
    set_row(5, "hold_full",   20, 20, 16'h6000, READY_LOW,    1'b0);
    set_row(6, "clear_flush", 6,  6,  16'h7000, READY_LOW,    1'b1);
    set_row(7, "after_clear", 4,  4,  16'h8000, READY_HIGH,   1'b0);
  endtask

  // A clear leaves only the first wide beat, already held by the consumer.
  task automatic add_expected(input int row, input logic [31:0] word, input logic [3:0] strb,
                              input logic [31:0] mask, inout int made);
    if (!test_clear[row] || made == 0) begin
      exp_data[exp_wr] = word & mask;
      exp_strb[exp_wr] = strb;
      exp_mask[exp_wr] = mask;
      exp_wr++;
    end
    made++;
  endtask

  // Lane 0 low, lane 1 high, last on lane 0 closes with upper strobes zero.
  task automatic build_expected(input int row);
    int          i;
    int          made;
    bit          upper;
    logic [31:0] word;
    logic [3:0]  strb;
    made  = 0;
    upper = 1'b0;
    word  = '0;
    strb  = '0;
    for (i = 0; i < test_beats[row]; i++) begin
      if (!upper) begin
        word = {16'h0000, beat_data(row, i)};
        strb = {2'b00, beat_strb(i)};
        if (beat_last(row, i)) begin
          add_expected(row, word, strb, 32'h0000_ffff, made);
        end else begin
          upper = 1'b1;
        end
      end else begin
        word[31:16] = beat_data(row, i);
        strb[3:2]   = beat_strb(i);
        add_expected(row, word, strb, 32'hffff_ffff, made);
        upper = 1'b0;
      end
    end
  endtask

  task automatic wait_ack(input int limit, output bit acked);
    int waited;
    waited = 0;
    acked  = o_ack;
    while (!acked && (limit == 0 || waited < limit)) begin
      @(posedge i_clk);
      #1;
      waited++;
      acked = o_ack;
    end
  endtask

  task automatic wait_ack_low();
    do begin
      @(posedge i_clk);
      #1;
    end while (o_ack);
  endtask

  task automatic report_value(input string what, input logic expected, input logic actual);
    $display("Error %s: %s expected %b, actual %b", cur_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("%s: ok", cur_name);
    end else begin
      $display("%s: %0d error(s)", cur_name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    tests_run++;
  endtask

  task automatic run_row(input int row);
    int i;
    int limit;
    int stalls;
    int mark_errors;
    int mark_full;
    bit acked;
    cur_name    = test_name[row];
    test_errors = 0;
    stalls      = 0;
    mark_errors = monitor_errors;
    mark_full   = full_count;
    limit       = (test_ready[row] == READY_LOW && !test_clear[row]) ? ACK_LIMIT : 0;
    build_expected(row);
    ready_mode = test_ready[row];
    for (i = 0; i < test_beats[row]; i++) begin
      i_data = beat_data(row, i);
      i_strb = beat_strb(i);
      i_last = beat_last(row, i);
      i_req  = 1'b1;
      wait_ack(limit, acked);
      if (!acked) begin
        // First stall lets one wide beat out, the next one releases the output.
        stalls++;
        if (stalls == 1) begin
          pulse_req++;
        end else begin
          ready_mode = READY_HIGH;
        end
        wait_ack(0, acked);
      end
      i_req = 1'b0;
      wait_ack_low();
    end
    if (test_clear[row]) begin
      repeat (4) @(posedge i_clk);
      #1;
      if (o_fifo_empty !== 1'b0) begin
        report_value("o_fifo_empty before clear", 1'b0, o_fifo_empty);
      end
      i_clear = 1'b1;
      @(posedge i_clk);
      #1 i_clear = 1'b0;
      if (o_fifo_empty !== 1'b1) begin
        report_value("o_fifo_empty after clear", 1'b1, o_fifo_empty);
      end
    end else if (test_ready[row] == READY_LOW) begin
      if (stalls == 0) begin
        $display("Error %s: o_ack kept rising while the output was held", cur_name);
        test_errors++;
      end
      if (full_count == mark_full) begin
        $display("Error %s: o_fifo_full never rose while the output was held", cur_name);
        test_errors++;
      end
    end
    ready_mode = READY_HIGH;
    while (exp_rd != exp_wr) begin
      @(posedge i_clk);
      #1;
    end
    // Idle cycles to catch any stray beat.
    repeat (6) @(posedge i_clk);
    #1;
    test_errors += monitor_errors - mark_errors;
    finish_test();
  endtask

  // Ready is chosen at the edge and driven just after it.
  always @(posedge i_clk) begin
    mode_now   = ready_mode;
    pulse_now  = (pulse_req != pulse_done);
    pulse_done = pulse_req;
    lcg_state  = lcg_next(lcg_state);
    #1;
    if (pulse_now) begin
      i_ready = 1'b1;
    end else if (mode_now == READY_RANDOM) begin
      i_ready = lcg_state[16];
    end else begin
      i_ready = (mode_now == READY_HIGH);
    end
  end

  // Inputs are steady here, so a transfer at the next edge is known.
  always @(negedge i_clk) begin
    if (o_fifo_full) begin
      full_count++;
    end
    if (o_valid && i_ready) begin
      if (exp_rd == exp_wr) begin
        $display("Error %s: wide beat %h arrived with none expected", cur_name, o_data);
        monitor_errors++;
      end else begin
        if (((o_data & exp_mask[exp_rd]) != exp_data[exp_rd]) ||
            (o_strb != exp_strb[exp_rd])) begin
          $display("Error %s: expected data %h strb %h, actual data %h strb %h", cur_name,
                   exp_data[exp_rd], exp_strb[exp_rd], o_data & exp_mask[exp_rd], o_strb);
          monitor_errors++;
        end
        exp_rd++;
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int row;
    int beat_total;
    i_rst_n = 1'b0;
    i_clear = 1'b0;
    i_req   = 1'b0;
    i_data  = '0;
    i_strb  = '0;
    i_last  = 1'b0;
    load_table();
    beat_total = 0;
    for (row = 0; row < NUM_ROWS; row++) begin
      beat_total += test_beats[row];
    end
    cycle_limit = 40 * beat_total + 200;
    repeat (3) @(posedge i_clk);
    #1 i_rst_n = 1'b1;
    if (o_ack !== 1'b0) begin
      report_value("o_ack", 1'b0, o_ack);
    end
    if (o_valid !== 1'b0) begin
      report_value("o_valid", 1'b0, o_valid);
    end
    if (o_fifo_full !== 1'b0) begin
      report_value("o_fifo_full", 1'b0, o_fifo_full);
    end
    if (o_fifo_empty !== 1'b1) begin
      report_value("o_fifo_empty", 1'b1, o_fifo_empty);
    end
    finish_test();
    // Receiver must see req low once before its first capture.
    repeat (2) @(posedge i_clk);
    #1;
    for (row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    repeat (10) @(posedge i_clk);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0 && monitor_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end
endmodule

// ==== wdata_packer.f ====
wdata_bus_pkg.sv
wdata_buf_pkg.sv
wdata_ram.sv
wdata_slicer.sv
wdata_fifo.sv
wdata_req_ack_rx.sv
wdata_lane_packer.sv
wdata_packer_top.sv
tb_wdata_packer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_wdata_packer
RTL_TOP   ?= wdata_packer_top
FILELIST  ?= wdata_packer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
